//--- isa_pkg.sv
package isa_pkg;

	typedef logic [31:0] word_t;

	localparam int unsigned REG_COUNT = 32;

	typedef enum logic [5:0] {
		OP_R_TYPE = 6'b000000,
		OP_J      = 6'b000010,
		OP_BEQ    = 6'b000100,
		OP_BNE    = 6'b000101,
		OP_ADDI   = 6'b001000,
		OP_LW     = 6'b100011,
		OP_SW     = 6'b101011
	} opcode_e;

	typedef enum logic [5:0] {
		FN_SLL   = 6'b000000,
		FN_SRL   = 6'b000010,
		FN_SRA   = 6'b000011,
		FN_SLLV  = 6'b000100,
		FN_SRAV  = 6'b000111,
		FN_BREAK = 6'b001101,
		FN_ADD   = 6'b100000,
		FN_SUB   = 6'b100010,
		FN_AND   = 6'b100100,
		FN_SLT   = 6'b101010
	} funct_e;

	// ----------------------------------------------------------
	// Three views of the same instruction word
	// ----------------------------------------------------------
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fields_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fields_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] target;
	} j_fields_t;

	typedef union packed {
		r_fields_t r;
		i_fields_t i;
		j_fields_t j;
	} instr_t;

endpackage

//--- ctrl_pkg.sv
package ctrl_pkg;

	typedef enum logic [2:0] {
		ALU_PASS_A = 3'b000,
		ALU_ADD    = 3'b001,
		ALU_SUB    = 3'b010,
		ALU_AND    = 3'b011,
		// Result is one or zero
		ALU_SLT    = 3'b111
	} alu_op_e;

	typedef enum logic [2:0] {
		SHIFT_HOLD        = 3'b000,
		SHIFT_LOAD        = 3'b001,
		SHIFT_LEFT        = 3'b010,
		SHIFT_RIGHT_LOGIC = 3'b011,
		SHIFT_RIGHT_ARITH = 3'b100
	} shift_op_e;

	// ----------------------------------------------------------
	// Datapath selects
	// ----------------------------------------------------------
	typedef enum logic {
		SRC_A_PC  = 1'b0,
		SRC_A_REG = 1'b1
	} src_a_e;

	typedef enum logic [1:0] {
		SRC_B_REG       = 2'b00,
		SRC_B_FOUR      = 2'b01,
		SRC_B_IMM       = 2'b10,
		SRC_B_IMM_SHIFT = 2'b11
	} src_b_e;

	typedef enum logic [1:0] {
		PC_SRC_ALU     = 2'b00,
		PC_SRC_ALU_OUT = 2'b01,
		PC_SRC_JUMP    = 2'b10
	} pc_src_e;

	typedef enum logic [1:0] {
		WB_ALU_OUT = 2'b00,
		WB_MDR     = 2'b01,
		WB_SHIFT   = 2'b10
	} wb_src_e;

	typedef enum logic {
		REG_DST_RT = 1'b0,
		REG_DST_RD = 1'b1
	} reg_dst_e;

endpackage

//--- ctrl_bus_if.sv
`timescale 1ns/100ps

interface ctrl_bus_if;

	// One-cycle strobes
	logic ir_write;
	logic pc_write;
	logic mem_write;
	logic mdr_write;
	logic ab_write;
	logic alu_out_write;
	logic reg_write;

	// Selects
	// Address comes from the ALU output register when addr_sel is high
	logic addr_sel;
	ctrl_pkg::pc_src_e pc_src;
	ctrl_pkg::src_a_e src_a;
	ctrl_pkg::src_b_e src_b;
	ctrl_pkg::alu_op_e alu_op;
	ctrl_pkg::shift_op_e shift_op;
	logic shift_amt_sel;
	ctrl_pkg::wb_src_e wb_src;
	ctrl_pkg::reg_dst_e reg_dst;

	// Status back from the ALU
	logic equal;

	modport ctrl (
		output ir_write, pc_write, mem_write, mdr_write, ab_write, alu_out_write, reg_write,
		output addr_sel, pc_src, src_a, src_b, alu_op, shift_op, shift_amt_sel,
		output wb_src, reg_dst,
		input equal
	);

	modport mem_path (input ir_write, pc_write, mdr_write, addr_sel, pc_src);
	modport reg_path (input ab_write, reg_write, wb_src, reg_dst);
	modport alu_path (input src_a, src_b, alu_op, alu_out_write, output equal);
	modport shift_path (input shift_op, shift_amt_sel);

endinterface

//--- control_unit.sv
`timescale 1ns/100ps

module control_unit (
	input logic clock,
	input logic reset,
	input isa_pkg::instr_t i_instr,
	ctrl_bus_if.ctrl bus,
	output logic o_halted
);

	typedef enum logic [3:0] {
		FETCH,
		DECODE,
		ALU_EXEC,
		ADDI_EXEC,
		REG_WB,
		SH_LOAD,
		SH_RUN,
		SH_WB,
		MEM_ADDR,
		LOAD_READ,
		LOAD_WB,
		STORE_WRITE,
		BRANCH,
		JUMP,
		HALT
	} state_e;

	state_e state;
	state_e next_state;
	isa_pkg::opcode_e opcode;
	isa_pkg::funct_e funct;
	ctrl_pkg::alu_op_e r_alu_op;
	ctrl_pkg::shift_op_e r_shift_op;

	assign opcode = isa_pkg::opcode_e'(i_instr.r.opcode);
	assign funct = isa_pkg::funct_e'(i_instr.r.funct);

	// Function code to ALU and shift operation
	always_comb begin
		r_alu_op = ctrl_pkg::ALU_ADD;
		r_shift_op = ctrl_pkg::SHIFT_LEFT;
		case (funct)
			isa_pkg::FN_SUB: r_alu_op = ctrl_pkg::ALU_SUB;
			isa_pkg::FN_AND: r_alu_op = ctrl_pkg::ALU_AND;
			isa_pkg::FN_SLT: r_alu_op = ctrl_pkg::ALU_SLT;
			isa_pkg::FN_SRL: r_shift_op = ctrl_pkg::SHIFT_RIGHT_LOGIC;
			isa_pkg::FN_SRA, isa_pkg::FN_SRAV: r_shift_op = ctrl_pkg::SHIFT_RIGHT_ARITH;
			default: r_alu_op = ctrl_pkg::ALU_ADD;
		endcase
	end

	// ----------------------------------------------------------
	// State sequencing
	// ----------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= FETCH;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = FETCH;
		case (state)
			FETCH: next_state = DECODE;
			DECODE: begin
				case (opcode)
					isa_pkg::OP_R_TYPE: begin
						case (funct)
							isa_pkg::FN_ADD, isa_pkg::FN_SUB, isa_pkg::FN_AND, isa_pkg::FN_SLT:
								next_state = ALU_EXEC;
							isa_pkg::FN_SLL, isa_pkg::FN_SRL, isa_pkg::FN_SRA,
							isa_pkg::FN_SLLV, isa_pkg::FN_SRAV:
								next_state = SH_LOAD;
							isa_pkg::FN_BREAK: next_state = HALT;
							default: next_state = FETCH;
						endcase
					end
					isa_pkg::OP_ADDI: next_state = ADDI_EXEC;
					isa_pkg::OP_BEQ, isa_pkg::OP_BNE: next_state = BRANCH;
					isa_pkg::OP_LW, isa_pkg::OP_SW: next_state = MEM_ADDR;
					isa_pkg::OP_J: next_state = JUMP;
					// Unknown opcode falls through as a no-op
					default: next_state = FETCH;
				endcase
			end
			ALU_EXEC, ADDI_EXEC: next_state = REG_WB;
			SH_LOAD: next_state = SH_RUN;
			SH_RUN: next_state = SH_WB;
			MEM_ADDR: next_state = (opcode == isa_pkg::OP_LW) ? LOAD_READ : STORE_WRITE;
			LOAD_READ: next_state = LOAD_WB;
			HALT: next_state = HALT;
			default: next_state = FETCH;
		endcase
	end

	// ----------------------------------------------------------
	// Strobes and selects
	// ----------------------------------------------------------
	always_comb begin
		bus.ir_write = 1'b0;
		bus.pc_write = 1'b0;
		bus.mem_write = 1'b0;
		bus.mdr_write = 1'b0;
		bus.ab_write = 1'b0;
		bus.alu_out_write = 1'b0;
		bus.reg_write = 1'b0;
		bus.addr_sel = 1'b0;
		bus.pc_src = ctrl_pkg::PC_SRC_ALU;
		bus.src_a = ctrl_pkg::SRC_A_PC;
		bus.src_b = ctrl_pkg::SRC_B_REG;
		bus.alu_op = ctrl_pkg::ALU_PASS_A;
		bus.shift_op = ctrl_pkg::SHIFT_HOLD;
		bus.shift_amt_sel = 1'b0;
		bus.wb_src = ctrl_pkg::WB_ALU_OUT;
		bus.reg_dst = ctrl_pkg::REG_DST_RT;
		case (state)
			FETCH: begin
				bus.ir_write = 1'b1;
				bus.pc_write = 1'b1;
				bus.src_b = ctrl_pkg::SRC_B_FOUR;
				bus.alu_op = ctrl_pkg::ALU_ADD;
			end
			DECODE: begin
				// Branch target computed ahead of the compare
				bus.ab_write = 1'b1;
				bus.alu_out_write = 1'b1;
				bus.src_b = ctrl_pkg::SRC_B_IMM_SHIFT;
				bus.alu_op = ctrl_pkg::ALU_ADD;
			end
			ALU_EXEC: begin
				bus.alu_out_write = 1'b1;
				bus.src_a = ctrl_pkg::SRC_A_REG;
				bus.alu_op = r_alu_op;
			end
			ADDI_EXEC, MEM_ADDR: begin
				bus.alu_out_write = 1'b1;
				bus.src_a = ctrl_pkg::SRC_A_REG;
				bus.src_b = ctrl_pkg::SRC_B_IMM;
				bus.alu_op = ctrl_pkg::ALU_ADD;
			end
			REG_WB: begin
				bus.reg_write = 1'b1;
				if (opcode == isa_pkg::OP_R_TYPE) begin
					bus.reg_dst = ctrl_pkg::REG_DST_RD;
				end
			end
			SH_LOAD: begin
				bus.shift_op = ctrl_pkg::SHIFT_LOAD;
				bus.shift_amt_sel = (funct == isa_pkg::FN_SLLV) || (funct == isa_pkg::FN_SRAV);
			end
			SH_RUN: bus.shift_op = r_shift_op;
			SH_WB: begin
				bus.reg_write = 1'b1;
				bus.wb_src = ctrl_pkg::WB_SHIFT;
				bus.reg_dst = ctrl_pkg::REG_DST_RD;
			end
			LOAD_READ: begin
				bus.addr_sel = 1'b1;
				bus.mdr_write = 1'b1;
			end
			LOAD_WB: begin
				bus.reg_write = 1'b1;
				bus.wb_src = ctrl_pkg::WB_MDR;
			end
			STORE_WRITE: begin
				bus.addr_sel = 1'b1;
				bus.mem_write = 1'b1;
			end
			BRANCH: begin
				bus.pc_src = ctrl_pkg::PC_SRC_ALU_OUT;
				bus.pc_write = (opcode == isa_pkg::OP_BEQ) ? bus.equal : !bus.equal;
			end
			JUMP: begin
				bus.pc_write = 1'b1;
				bus.pc_src = ctrl_pkg::PC_SRC_JUMP;
			end
			default: bus.alu_op = ctrl_pkg::ALU_PASS_A;
		endcase
	end

	assign o_halted = (state == HALT);

	// Memory and register file are never written in the same cycle
	assert property (@(posedge clock) disable iff (reset) !(bus.mem_write && bus.reg_write));

	// Only reset leaves the halt state
	assert property (@(posedge clock) o_halted && !reset |=> o_halted);

endmodule

//--- memory_access.sv
`timescale 1ns/100ps

module memory_access #(
	parameter isa_pkg::word_t RESET_PC = 32'h0000_0000
) (
	input logic clock,
	input logic reset,
	ctrl_bus_if.mem_path bus,
	input isa_pkg::word_t i_alu_result,
	input isa_pkg::word_t i_alu_out,
	input isa_pkg::word_t i_mem_rdata,
	output isa_pkg::word_t o_mem_addr,
	output isa_pkg::word_t o_pc,
	output isa_pkg::word_t o_mdr,
	output isa_pkg::instr_t o_instr
);

	isa_pkg::word_t pc;
	isa_pkg::word_t next_pc;
	isa_pkg::instr_t ir;
	isa_pkg::word_t mdr;

	// Jump keeps the top bits of the incremented PC
	always_comb begin
		case (bus.pc_src)
			ctrl_pkg::PC_SRC_ALU: next_pc = i_alu_result;
			ctrl_pkg::PC_SRC_ALU_OUT: next_pc = i_alu_out;
			ctrl_pkg::PC_SRC_JUMP: next_pc = {pc[31:28], ir.j.target, 2'b00};
			default: next_pc = pc;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= RESET_PC;
		end else if (bus.pc_write) begin
			pc <= next_pc;
		end
	end

	always_ff @(posedge clock) begin
		if (bus.ir_write) begin
			ir <= i_mem_rdata;
		end
		if (bus.mdr_write) begin
			mdr <= i_mem_rdata;
		end
	end

	assign o_mem_addr = bus.addr_sel ? i_alu_out : pc;
	assign o_pc = pc;
	assign o_mdr = mdr;
	assign o_instr = ir;

endmodule

//--- register_file.sv
`timescale 1ns/100ps

module register_file (
	input logic clock,
	input logic reset,
	ctrl_bus_if.reg_path bus,
	input isa_pkg::instr_t i_instr,
	input isa_pkg::word_t i_alu_out,
	input isa_pkg::word_t i_mdr,
	input isa_pkg::word_t i_shift,
	output isa_pkg::word_t o_a,
	output isa_pkg::word_t o_b
);

	isa_pkg::word_t regs [isa_pkg::REG_COUNT];
	isa_pkg::word_t rs_data;
	isa_pkg::word_t rt_data;
	isa_pkg::word_t wb_data;
	logic [4:0] dest;

	assign rs_data = (i_instr.r.rs == 5'd0) ? '0 : regs[i_instr.r.rs];
	assign rt_data = (i_instr.r.rt == 5'd0) ? '0 : regs[i_instr.r.rt];
	assign dest = (bus.reg_dst == ctrl_pkg::REG_DST_RD) ? i_instr.r.rd : i_instr.r.rt;

	always_comb begin
		case (bus.wb_src)
			ctrl_pkg::WB_ALU_OUT: wb_data = i_alu_out;
			ctrl_pkg::WB_MDR: wb_data = i_mdr;
			ctrl_pkg::WB_SHIFT: wb_data = i_shift;
			default: wb_data = i_alu_out;
		endcase
	end

	always_ff @(posedge clock) begin
		if (bus.reg_write && dest != 5'd0) begin
			regs[dest] <= wb_data;
		end
	end

	// Operand registers
	always_ff @(posedge clock) begin
		if (reset) begin
			o_a <= '0;
			o_b <= '0;
		end else if (bus.ab_write) begin
			o_a <= rs_data;
			o_b <= rt_data;
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		bus.ab_write && i_instr.r.rs == 5'd0 |=> o_a == '0);

endmodule

//--- alu.sv
`timescale 1ns/100ps

module alu (
	input logic clock,
	input logic reset,
	ctrl_bus_if.alu_path bus,
	input isa_pkg::instr_t i_instr,
	input isa_pkg::word_t i_pc,
	input isa_pkg::word_t i_a,
	input isa_pkg::word_t i_b,
	output isa_pkg::word_t o_result,
	output isa_pkg::word_t o_alu_out
);

	isa_pkg::word_t op_a;
	isa_pkg::word_t op_b;
	isa_pkg::word_t imm_ext;

	assign imm_ext = {{16{i_instr.i.imm[15]}}, i_instr.i.imm};
	assign op_a = (bus.src_a == ctrl_pkg::SRC_A_REG) ? i_a : i_pc;

	always_comb begin
		case (bus.src_b)
			ctrl_pkg::SRC_B_REG: op_b = i_b;
			ctrl_pkg::SRC_B_FOUR: op_b = 32'd4;
			ctrl_pkg::SRC_B_IMM: op_b = imm_ext;
			default: op_b = {imm_ext[29:0], 2'b00};
		endcase
	end

	always_comb begin
		case (bus.alu_op)
			ctrl_pkg::ALU_PASS_A: o_result = op_a;
			ctrl_pkg::ALU_ADD: o_result = op_a + op_b;
			ctrl_pkg::ALU_SUB: o_result = op_a - op_b;
			ctrl_pkg::ALU_AND: o_result = op_a & op_b;
			ctrl_pkg::ALU_SLT: o_result = {31'd0, $signed(op_a) < $signed(op_b)};
			default: o_result = '0;
		endcase
	end

	// Branch compare works on the operand registers directly
	assign bus.equal = (i_a == i_b);

	always_ff @(posedge clock) begin
		if (reset) begin
			o_alu_out <= '0;
		end else if (bus.alu_out_write) begin
			o_alu_out <= o_result;
		end
	end

endmodule

//--- shifter.sv
`timescale 1ns/100ps

module shifter (
	input logic clock,
	input logic reset,
	ctrl_bus_if.shift_path bus,
	input isa_pkg::instr_t i_instr,
	input isa_pkg::word_t i_a,
	input isa_pkg::word_t i_b,
	output isa_pkg::word_t o_shift
);

	isa_pkg::word_t value;
	logic [4:0] amount;

	always_ff @(posedge clock) begin
		if (reset) begin
			value <= '0;
			amount <= '0;
		end else begin
			case (bus.shift_op)
				ctrl_pkg::SHIFT_LOAD: begin
					value <= i_b;
					// Variable shifts take the amount from rs
					amount <= bus.shift_amt_sel ? i_a[4:0] : i_instr.r.shamt;
				end
				ctrl_pkg::SHIFT_LEFT: value <= value << amount;
				ctrl_pkg::SHIFT_RIGHT_LOGIC: value <= value >> amount;
				ctrl_pkg::SHIFT_RIGHT_ARITH: value <= $signed(value) >>> amount;
				default: value <= value;
			endcase
		end
	end

	assign o_shift = value;

endmodule

//--- multicycle_cpu.sv
`timescale 1ns/100ps

module multicycle_cpu #(
	parameter isa_pkg::word_t RESET_PC = 32'h0000_0000
) (
	input logic clock,
	input logic reset,
	input isa_pkg::word_t i_mem_rdata,
	output isa_pkg::word_t o_mem_addr,
	output isa_pkg::word_t o_mem_wdata,
	output logic o_mem_write,
	output logic o_halted
);

	isa_pkg::instr_t instr;
	isa_pkg::word_t pc;
	isa_pkg::word_t mdr;
	isa_pkg::word_t alu_result;
	isa_pkg::word_t alu_out;
	isa_pkg::word_t reg_a;
	isa_pkg::word_t reg_b;
	isa_pkg::word_t shift_value;

	ctrl_bus_if bus ();

	control_unit i_control_unit (
		.clock(clock), .reset(reset), .i_instr(instr), .bus(bus), .o_halted(o_halted)
	);

	memory_access #(.RESET_PC(RESET_PC)) i_memory_access (
		.clock(clock), .reset(reset), .bus(bus),
		.i_alu_result(alu_result), .i_alu_out(alu_out), .i_mem_rdata(i_mem_rdata),
		.o_mem_addr(o_mem_addr), .o_pc(pc), .o_mdr(mdr), .o_instr(instr)
	);

	register_file i_register_file (
		.clock(clock), .reset(reset), .bus(bus), .i_instr(instr),
		.i_alu_out(alu_out), .i_mdr(mdr), .i_shift(shift_value), .o_a(reg_a), .o_b(reg_b)
	);

	alu i_alu (
		.clock(clock), .reset(reset), .bus(bus), .i_instr(instr), .i_pc(pc),
		.i_a(reg_a), .i_b(reg_b), .o_result(alu_result), .o_alu_out(alu_out)
	);

	shifter i_shifter (
		.clock(clock), .reset(reset), .bus(bus), .i_instr(instr),
		.i_a(reg_a), .i_b(reg_b), .o_shift(shift_value)
	);

	// Store data is the B operand register
	assign o_mem_wdata = reg_b;
	assign o_mem_write = bus.mem_write;

endmodule

//--- tb_isa_model.svh
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

// Architectural state of the model
isa_pkg::word_t model_mem [MEM_WORDS];
isa_pkg::word_t model_regs [isa_pkg::REG_COUNT];
isa_pkg::word_t exp_addr [$];
isa_pkg::word_t exp_data [$];

function automatic isa_pkg::word_t sign_ext(input logic [15:0] imm);
	return {{16{imm[15]}}, imm};
endfunction

task automatic run_model();
	isa_pkg::word_t pc;
	isa_pkg::instr_t ins;
	isa_pkg::word_t a;
	isa_pkg::word_t b;
	isa_pkg::word_t addr;
	isa_pkg::word_t res;
	logic [4:0] dest;
	logic wb;
	logic done;
	int steps;
	for (int k = 0; k < MEM_WORDS; k++) begin
		model_mem[k] = image[k];
	end
	for (int r = 0; r < isa_pkg::REG_COUNT; r++) begin
		model_regs[r] = '0;
	end
	pc = RESET_PC;
	done = 1'b0;
	steps = 0;
	while (!done && steps < MAX_STEPS) begin
		ins = model_mem[pc[9:2]];
		pc = pc + 32'd4;
		a = model_regs[ins.r.rs];
		b = model_regs[ins.r.rt];
		addr = a + sign_ext(ins.i.imm);
		res = '0;
		wb = 1'b0;
		dest = ins.r.rt;
		case (ins.r.opcode)
			isa_pkg::OP_R_TYPE: begin
				wb = 1'b1;
				dest = ins.r.rd;
				case (ins.r.funct)
					isa_pkg::FN_ADD: res = a + b;
					isa_pkg::FN_SUB: res = a - b;
					isa_pkg::FN_AND: res = a & b;
					isa_pkg::FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					isa_pkg::FN_SLL: res = b << ins.r.shamt;
					isa_pkg::FN_SRL: res = b >> ins.r.shamt;
					isa_pkg::FN_SRA: res = $signed(b) >>> ins.r.shamt;
					isa_pkg::FN_SLLV: res = b << a[4:0];
					isa_pkg::FN_SRAV: res = $signed(b) >>> a[4:0];
					isa_pkg::FN_BREAK: begin
						wb = 1'b0;
						done = 1'b1;
					end
					default: wb = 1'b0;
				endcase
			end
			isa_pkg::OP_ADDI: begin
				wb = 1'b1;
				res = addr;
			end
			isa_pkg::OP_LW: begin
				wb = 1'b1;
				res = model_mem[addr[9:2]];
			end
			isa_pkg::OP_SW: begin
				model_mem[addr[9:2]] = b;
				exp_addr.push_back(addr);
				exp_data.push_back(b);
			end
			// Branch offset counts words from the next instruction
			isa_pkg::OP_BEQ: if (a == b) pc = pc + (sign_ext(ins.i.imm) << 2);
			isa_pkg::OP_BNE: if (a != b) pc = pc + (sign_ext(ins.i.imm) << 2);
			isa_pkg::OP_J: pc = {pc[31:28], ins.j.target, 2'b00};
			default: wb = 1'b0;
		endcase
		if (wb && dest != 5'd0) begin
			model_regs[dest] = res;
		end
		steps++;
	end
endtask

`endif

//--- tb_multicycle_cpu.sv
`timescale 1ns/100ps

module tb_multicycle_cpu;

	localparam isa_pkg::word_t RESET_PC = 32'h0000_0000;
	localparam int MEM_WORDS = 256;
	localparam int PROG_LEN = 40;
	localparam int DATA_BASE = 64;
	localparam int DATA_WORDS = 64;
	localparam int MAX_CYCLES = 4000;
	localparam int MAX_STEPS = 1000;

	logic clock;
	logic reset;
	isa_pkg::word_t mem_rdata;
	isa_pkg::word_t mem_addr;
	isa_pkg::word_t mem_wdata;
	logic mem_write;
	logic halted;

	isa_pkg::word_t image [MEM_WORDS];
	isa_pkg::word_t mem [MEM_WORDS];
	int seed;
	int value_errors;
	int other_errors;
	int store_count;
	int cycles;

	`include "tb_isa_model.svh"

	multicycle_cpu #(.RESET_PC(RESET_PC)) i_multicycle_cpu (
		.clock(clock), .reset(reset), .i_mem_rdata(mem_rdata), .o_mem_addr(mem_addr),
		.o_mem_wdata(mem_wdata), .o_mem_write(mem_write), .o_halted(halted)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// Memory takes the program image while reset is held
	assign mem_rdata = mem[mem_addr[9:2]];

	always @(posedge clock) begin
		if (reset) begin
			for (int k = 0; k < MEM_WORDS; k++) begin
				mem[k] = image[k];
			end
		end else if (mem_write) begin
			mem[mem_addr[9:2]] = mem_wdata;
		end
	end

	// ----------------------------------------------------------
	// Program generation
	// ----------------------------------------------------------
	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic logic [4:0] rand_reg();
		return 5'(rand_below(8));
	endfunction

	function automatic logic [15:0] data_offset();
		return 16'(4 * (DATA_BASE + rand_below(DATA_WORDS)));
	endfunction

	function automatic isa_pkg::word_t r_word(input logic [5:0] funct, input logic [4:0] rs,
			input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] shamt);
		return {6'b000000, rs, rt, rd, shamt, funct};
	endfunction

	function automatic isa_pkg::word_t i_word(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic build_program();
		int idx;
		int kind;
		int span;
		int target;
		logic [4:0] dest;
		logic [5:0] fn;
		logic [5:0] br_op;
		for (int k = 0; k < MEM_WORDS; k++) begin
			image[k] = $random(seed);
		end
		// Registers 1 to 7 get known values first
		for (int r = 1; r < 8; r++) begin
			image[r - 1] = i_word(isa_pkg::OP_ADDI, 5'd0, 5'(r), 16'($random(seed)));
		end
		idx = 7;
		while (idx < PROG_LEN) begin
			kind = rand_below(7);
			dest = 5'(1 + rand_below(7));
			span = (PROG_LEN - idx < 4) ? PROG_LEN - idx : 4;
			target = idx + 1 + rand_below(span);
			case (kind)
				0: begin
					case (rand_below(4))
						0: fn = isa_pkg::FN_ADD;
						1: fn = isa_pkg::FN_SUB;
						2: fn = isa_pkg::FN_AND;
						default: fn = isa_pkg::FN_SLT;
					endcase
					image[idx] = r_word(fn, rand_reg(), rand_reg(), dest, 5'd0);
				end
				1: begin
					case (rand_below(5))
						0: fn = isa_pkg::FN_SLL;
						1: fn = isa_pkg::FN_SRL;
						2: fn = isa_pkg::FN_SRA;
						3: fn = isa_pkg::FN_SLLV;
						default: fn = isa_pkg::FN_SRAV;
					endcase
					image[idx] = r_word(fn, rand_reg(), rand_reg(), dest, 5'(rand_below(32)));
				end
				2: image[idx] = i_word(isa_pkg::OP_ADDI, rand_reg(), dest, 16'($random(seed)));
				3: image[idx] = i_word(isa_pkg::OP_LW, 5'd0, dest, data_offset());
				4: begin
					br_op = (rand_below(2) == 0) ? isa_pkg::OP_BEQ : isa_pkg::OP_BNE;
					image[idx] = i_word(br_op, rand_reg(), rand_reg(), 16'(target - idx - 1));
				end
				5: image[idx] = {isa_pkg::OP_J, 26'(target)};
				default: image[idx] = i_word(isa_pkg::OP_SW, 5'd0, rand_reg(), data_offset());
			endcase
			idx++;
			// Computed and loaded values go straight out to memory
			if (kind < 4 && idx < PROG_LEN) begin
				image[idx] = i_word(isa_pkg::OP_SW, 5'd0, dest, data_offset());
				idx++;
			end
		end
		image[PROG_LEN] = r_word(isa_pkg::FN_BREAK, 5'd0, 5'd0, 5'd0, 5'd0);
	endtask

	// ----------------------------------------------------------
	// Checks
	// ----------------------------------------------------------
	task automatic check_store();
		assert (store_count < exp_addr.size()) else begin
			$display("Store seen after all %0d expected stores", exp_addr.size());
			other_errors++;
		end
		if (store_count < exp_addr.size()) begin
			assert (mem_addr == exp_addr[store_count]) else begin
				$display("** Error store_addr %0d: expected %h, actual %h",
					store_count, exp_addr[store_count], mem_addr);
				value_errors++;
			end
			assert (mem_wdata == exp_data[store_count]) else begin
				$display("** Error store_data %0d: expected %h, actual %h",
					store_count, exp_data[store_count], mem_wdata);
				value_errors++;
			end
		end
		store_count++;
	endtask

	initial begin
		seed = 16;
		value_errors = 0;
		other_errors = 0;
		store_count = 0;
		reset = 1'b1;
		build_program();
		run_model();
		repeat (3) begin
			@(negedge clock);
			assert (!mem_write && !halted) else begin
				$display("Store or halt raised while reset was held");
				other_errors++;
			end
		end
		reset = 1'b0;
		assert (mem_addr == RESET_PC) else begin
			$display("** Error reset_addr: expected %h, actual %h", RESET_PC, mem_addr);
			value_errors++;
		end
		cycles = 0;
		while (!halted && cycles < MAX_CYCLES) begin
			if (mem_write) begin
				check_store();
			end
			@(negedge clock);
			cycles++;
		end
		assert (halted) else begin
			$display("Timeout, CPU did not halt within %0d cycles", MAX_CYCLES);
			other_errors++;
		end
		if (halted) begin
			assert (store_count == exp_addr.size()) else begin
				$display("** Error store_count: expected %0d, actual %0d",
					exp_addr.size(), store_count);
				value_errors++;
			end
			repeat (20) begin
				@(negedge clock);
				assert (halted && !mem_write) else begin
					$display("Halt output dropped or a store happened after halt");
					other_errors++;
				end
			end
		end
		$display("Errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- multicycle_cpu.f
+incdir+.
isa_pkg.sv
ctrl_pkg.sv
ctrl_bus_if.sv
control_unit.sv
memory_access.sv
register_file.sv
alu.sv
shifter.sv
multicycle_cpu.sv
tb_multicycle_cpu.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the multicycle CPU testbench with Verilator
set -e

rm -f sim.log
verilator --binary --assert --timescale 1ns/100ps \
	--top-module tb_multicycle_cpu \
	-f multicycle_cpu.f \
	--Mdir obj_dir -o sim_multicycle_cpu

./obj_dir/sim_multicycle_cpu | tee sim.log

if grep -q "Test FAILED" sim.log; then
	exit 1
fi
exit 0
